// File: verilog/sdmac_pkg.sv
// Register offsets, FSM state types, FIFO and strobe sizing, CONTR and ISTR bit positions
package sdmac_pkg;

    // Word offsets seen on s_adr_i[6:2]
    typedef enum logic [4:0] {
        REG_WTC     = 5'h01,    // 0x04
        REG_CONTR   = 5'h02,    // 0x08
        REG_ACR     = 5'h03,    // 0x0C
        REG_ST_DMA  = 5'h04,    // 0x10
        REG_SP_DMA  = 5'h05,    // 0x14
        REG_CLR_INT = 5'h06,    // 0x18
        REG_ISTR    = 5'h07,    // 0x1C
        REG_SCSI    = 5'h10     // 0x40, WD33C93 register port
    } reg_addr_e;

    // Peripheral port sequencer
    typedef enum logic [2:0] {
        PS_IDLE,
        PS_CPU_STROBE,
        PS_CPU_RECOVER,
        PS_DMA_HI,
        PS_DMA_LO,
        PS_DMA_RECOVER
    } scsi_state_e;

    // Memory side bus master
    typedef enum logic [1:0] {
        MS_IDLE,
        MS_BUS_CYCLE,
        MS_GAP
    } master_state_e;

    localparam int FIFO_DEPTH         = 8;
    localparam int FIFO_AW            = 3;
    localparam int PORT_STROBE_CYCLES = 3;
    localparam int STROBE_CNT_W       = 2;  // Wide enough for PORT_STROBE_CYCLES

    localparam int CONTR_DIR    = 1;    // 1 = memory to SCSI
    localparam int CONTR_INTENA = 2;
    localparam int CONTR_PRESET = 4;

    localparam int ISTR_INT_DONE = 0;
    localparam int ISTR_INT_SCSI = 1;
    localparam int ISTR_FE       = 2;
    localparam int ISTR_FF       = 3;

endpackage

// File: verilog/sdmac_fifo.sv
// Synchronous 32-bit word FIFO with fall-through head, clear, full and empty flags
module sdmac_fifo import sdmac_pkg::*; (
    input  logic        sclk_i,
    input  logic        arst_n_i,
    input  logic        clear_i,
    input  logic        push_i,
    input  logic [31:0] push_data_i,
    input  logic        pop_i,
    output logic [31:0] pop_data_o,
    output logic        full_o,
    output logic        empty_o
);

    logic [31:0]        mem [FIFO_DEPTH];
    logic [FIFO_AW-1:0] wr_ptr;
    logic [FIFO_AW-1:0] rd_ptr;
    logic [FIFO_AW:0]   count;

    assign pop_data_o = mem[rd_ptr];    // Head visible before the pop
    assign full_o     = (count == (FIFO_AW + 1)'(FIFO_DEPTH));
    assign empty_o    = (count == '0);

    always_ff @(posedge sclk_i) begin
        if (push_i)
            mem[wr_ptr] <= push_data_i;
    end

    always_ff @(posedge sclk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (clear_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_i)
                wr_ptr <= wr_ptr + 1'b1;                // Wraps at depth
            if (pop_i)
                rd_ptr <= rd_ptr + 1'b1;
            case ({push_i, pop_i})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    a_no_overflow: assert property (@(posedge sclk_i) disable iff (!arst_n_i)
        full_o |-> !push_i);
    a_no_underflow: assert property (@(posedge sclk_i) disable iff (!arst_n_i)
        empty_o |-> !pop_i);

endmodule

// File: verilog/sdmac_regs.sv
// Wishbone slave register block with WTC, CONTR and ACR, DMA strobes, ISTR and interrupt
module sdmac_regs import sdmac_pkg::*; (
    input  logic        sclk_i,
    input  logic        arst_n_i,
    input  logic        s_cyc_i,
    input  logic        s_stb_i,
    input  logic        s_we_i,
    input  logic [6:2]  s_adr_i,
    input  logic [31:0] s_dat_i,
    input  logic        scsi_done_i,
    input  logic [15:0] scsi_rdata_i,
    input  logic        word_done_i,
    input  logic        port_idle_i,
    input  logic        fifo_empty_i,
    input  logic        fifo_full_i,
    input  logic        intr_i,
    output logic [31:0] s_dat_o,
    output logic        s_ack_o,
    output logic        scsi_req_o,
    output logic        scsi_we_o,
    output logic [15:0] scsi_wdata_o,
    output logic        dma_run_o,
    output logic        dma_dir_o,
    output logic        dma_start_o,
    output logic        preset_o,
    output logic [31:0] acr_o,
    output logic        int_o
);

    reg_addr_e   addr;
    logic        access;
    logic        is_scsi;
    logic        wr;
    logic [31:0] wtc;
    logic [7:0]  contr;
    logic        dma_en;
    logic        int_done;
    logic        done_cond;
    logic [3:0]  istr;

    assign addr    = reg_addr_e'(s_adr_i);
    assign access  = s_cyc_i & s_stb_i & ~s_ack_o;     // New cycle, not yet acked
    assign is_scsi = (addr == REG_SCSI);
    assign wr      = access & s_we_i & ~is_scsi;

    assign dma_start_o = wr & (addr == REG_ST_DMA);
    assign dma_run_o   = dma_en & (wtc != '0);
    assign dma_dir_o   = contr[CONTR_DIR];
    assign preset_o    = contr[CONTR_PRESET];

    // Count spent, FIFO drained, and for memory to SCSI the last half on the chip
    assign done_cond = dma_en & (wtc == '0) & fifo_empty_i & (port_idle_i | ~dma_dir_o);

    always_comb begin
        istr                = '0;
        istr[ISTR_INT_DONE] = int_done;
        istr[ISTR_INT_SCSI] = intr_i;
        istr[ISTR_FE]       = fifo_empty_i;
        istr[ISTR_FF]       = fifo_full_i;
    end

    // Slave handshake and window request
    always_ff @(posedge sclk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            s_ack_o    <= 1'b0;
            scsi_req_o <= 1'b0;
        end else begin
            s_ack_o <= (access & ~is_scsi) | scsi_done_i;  // Window ack waits for the port
            if (scsi_done_i)
                scsi_req_o <= 1'b0;
            else if (access && is_scsi)
                scsi_req_o <= 1'b1;
        end
    end

    always_ff @(posedge sclk_i) begin
        if (access && is_scsi && !scsi_req_o) begin
            scsi_we_o    <= s_we_i;
            scsi_wdata_o <= s_dat_i[15:0];
        end
        if (scsi_done_i) begin
            s_dat_o <= {16'h0000, scsi_rdata_i};
        end else if (access) begin
            case (addr)
                REG_WTC:   s_dat_o <= wtc;
                REG_CONTR: s_dat_o <= {24'h000000, contr};
                REG_ACR:   s_dat_o <= acr_o;
                REG_ISTR:  s_dat_o <= {28'h0000000, istr};
                default:   s_dat_o <= '0;                  // Strobes read as zero
            endcase
        end
    end

    always_ff @(posedge sclk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wtc      <= '0;
            contr    <= '0;
            acr_o    <= '0;
            dma_en   <= 1'b0;
            int_done <= 1'b0;
            int_o    <= 1'b0;
        end else begin
            if (wr && addr == REG_WTC)
                wtc <= s_dat_i;
            else if (word_done_i)
                wtc <= wtc - 32'd1;

            if (wr && addr == REG_ACR)
                acr_o <= s_dat_i;
            else if (word_done_i)
                acr_o <= acr_o + 32'd4;                 // Next longword

            if (wr && addr == REG_CONTR)
                contr <= s_dat_i[7:0];

            if (dma_start_o)
                dma_en <= 1'b1;
            else if ((wr && addr == REG_SP_DMA) || done_cond)
                dma_en <= 1'b0;

            if (done_cond)
                int_done <= 1'b1;
            else if (wr && addr == REG_CLR_INT)
                int_done <= 1'b0;

            int_o <= contr[CONTR_INTENA] & (int_done | intr_i);
        end
    end

    a_ack_single: assert property (@(posedge sclk_i) disable iff (!arst_n_i)
        s_ack_o |=> !s_ack_o);

endmodule

// File: verilog/scsi_port_sm.sv
// Peripheral port sequencer for CPU window accesses and DMA half-word pairs
module scsi_port_sm import sdmac_pkg::*; (
    input  logic        sclk_i,
    input  logic        arst_n_i,
    input  logic        cpu_req_i,
    input  logic        cpu_we_i,
    input  logic [15:0] cpu_wdata_i,
    input  logic        dma_run_i,
    input  logic        dma_dir_i,
    input  logic        preset_i,
    input  logic        dreq_n_i,
    input  logic [15:0] pd_i,
    input  logic [31:0] fifo_data_i,
    input  logic        fifo_full_i,
    input  logic        fifo_empty_i,
    output logic        cpu_done_o,
    output logic [15:0] cpu_rdata_o,
    output logic        fifo_push_o,
    output logic [31:0] fifo_push_data_o,
    output logic        fifo_pop_o,
    output logic        port_idle_o,
    output logic [15:0] pd_o,
    output logic        pd_oe_o,
    output logic        dack_n_o,
    output logic        css_n_o,
    output logic        ior_n_o,
    output logic        iow_n_o
);

    scsi_state_e             state;
    logic [STROBE_CNT_W-1:0] cnt;
    logic                    last;
    logic                    lo_half;   // Recovery follows the low half
    logic                    strobe;
    logic                    rd_dir;    // Strobe reads from the chip
    logic                    cpu_phase;
    logic                    dma_phase;
    logic                    hi_phase;
    logic                    dma_ok;
    logic [15:0]             hi_q;

    assign last   = (cnt == STROBE_CNT_W'(PORT_STROBE_CYCLES - 1));
    assign strobe = state inside {PS_CPU_STROBE, PS_DMA_HI, PS_DMA_LO};

    // Memory to SCSI keeps draining fetched words after the count has run out
    assign dma_ok = ~dreq_n_i & (dma_dir_i ? ~fifo_empty_i : dma_run_i & ~fifo_full_i);

    always_ff @(posedge sclk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state   <= PS_IDLE;
            cnt     <= '0;
            lo_half <= 1'b0;
        end else begin
            cnt <= (strobe && !last) ? cnt + 1'b1 : '0;
            case (state)
                PS_IDLE: begin
                    if (cpu_req_i)
                        state <= PS_CPU_STROBE;         // CPU goes ahead of DMA
                    else if (dma_ok)
                        state <= PS_DMA_HI;
                end
                PS_CPU_STROBE: begin
                    if (last)
                        state <= PS_CPU_RECOVER;
                end
                PS_CPU_RECOVER: state <= PS_IDLE;
                PS_DMA_HI: begin
                    if (last) begin
                        state   <= PS_DMA_RECOVER;
                        lo_half <= 1'b0;
                    end
                end
                PS_DMA_LO: begin
                    if (last) begin
                        state   <= PS_DMA_RECOVER;
                        lo_half <= 1'b1;
                    end
                end
                PS_DMA_RECOVER: begin
                    if (lo_half)
                        state <= PS_IDLE;
                    else if (!dreq_n_i)
                        state <= PS_DMA_LO;             // Low half needs its own DREQ
                end
                default: state <= PS_IDLE;
            endcase
        end
    end

    // Sample read data in the last strobe cycle
    always_ff @(posedge sclk_i) begin
        if (state == PS_CPU_STROBE && last && !cpu_we_i)
            cpu_rdata_o <= pd_i;
        if (state == PS_DMA_HI && last && !dma_dir_i)
            hi_q <= pd_i;
    end

    assign cpu_phase = state inside {PS_CPU_STROBE, PS_CPU_RECOVER};
    assign dma_phase = state inside {PS_DMA_HI, PS_DMA_LO, PS_DMA_RECOVER};
    assign hi_phase  = (state == PS_DMA_HI) || (state == PS_DMA_RECOVER && !lo_half);
    assign rd_dir    = (state == PS_CPU_STROBE) ? ~cpu_we_i : ~dma_dir_i;

    assign css_n_o  = ~(state == PS_CPU_STROBE);
    assign dack_n_o = ~(state inside {PS_DMA_HI, PS_DMA_LO});
    assign ior_n_o  = ~(preset_i | (strobe & rd_dir));  // Preset pulls both strobes
    assign iow_n_o  = ~(preset_i | (strobe & ~rd_dir));

    // Write data held through recovery
    assign pd_oe_o = (cpu_phase & cpu_we_i) | (dma_phase & dma_dir_i);
    assign pd_o    = cpu_phase ? cpu_wdata_i :
                     hi_phase  ? fifo_data_i[31:16] : fifo_data_i[15:0];

    assign cpu_done_o       = (state == PS_CPU_RECOVER);
    assign port_idle_o      = (state == PS_IDLE);
    assign fifo_push_o      = (state == PS_DMA_LO) & last & ~dma_dir_i;
    assign fifo_push_data_o = {hi_q, pd_i};
    assign fifo_pop_o       = (state == PS_DMA_RECOVER) & lo_half & dma_dir_i;

    // Each half holds DACK with exactly one strobe for the whole strobe time
    a_dma_strobe_len: assert property (@(posedge sclk_i) disable iff (!arst_n_i || preset_i)
        $fell(dack_n_o) |-> (!dack_n_o && (ior_n_o != iow_n_o))[*PORT_STROBE_CYCLES]
                            ##1 dack_n_o);

endmodule

// File: verilog/dma_master_sm.sv
// Wishbone classic bus master moving one FIFO word per cycle to or from memory
module dma_master_sm import sdmac_pkg::*; (
    input  logic        sclk_i,
    input  logic        arst_n_i,
    input  logic        dma_run_i,
    input  logic        dma_dir_i,
    input  logic [31:0] acr_i,
    input  logic [31:0] fifo_data_i,
    input  logic        fifo_empty_i,
    input  logic        fifo_full_i,
    input  logic [31:0] m_dat_i,
    input  logic        m_ack_i,
    output logic        m_cyc_o,
    output logic        m_stb_o,
    output logic        m_we_o,
    output logic [31:0] m_adr_o,
    output logic [31:0] m_dat_o,
    output logic        fifo_push_o,
    output logic [31:0] fifo_push_data_o,
    output logic        fifo_pop_o,
    output logic        word_done_o
);

    master_state_e state;
    logic          start;

    // Room or data for one whole word
    assign start = dma_run_i & (dma_dir_i ? ~fifo_full_i : ~fifo_empty_i);

    always_ff @(posedge sclk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state  <= MS_IDLE;
            m_we_o <= 1'b0;
        end else begin
            case (state)
                MS_IDLE, MS_GAP: begin
                    if (start) begin
                        state  <= MS_BUS_CYCLE;
                        m_we_o <= ~dma_dir_i;           // SCSI to memory writes
                    end else begin
                        state <= MS_IDLE;
                    end
                end
                MS_BUS_CYCLE: begin
                    if (m_ack_i)
                        state <= MS_GAP;                // Lets count and ACR settle
                end
                default: state <= MS_IDLE;
            endcase
        end
    end

    // Address and write data frozen for the whole cycle
    always_ff @(posedge sclk_i) begin
        if (state != MS_BUS_CYCLE && start) begin
            m_adr_o <= acr_i;
            m_dat_o <= fifo_data_i;
        end
    end

    assign m_cyc_o = (state == MS_BUS_CYCLE);
    assign m_stb_o = m_cyc_o;

    assign word_done_o      = m_cyc_o & m_ack_i;
    assign fifo_pop_o       = word_done_o & m_we_o;
    assign fifo_push_o      = word_done_o & ~m_we_o;
    assign fifo_push_data_o = m_dat_i;

    a_stb_held: assert property (@(posedge sclk_i) disable iff (!arst_n_i)
        (m_stb_o && !m_ack_i) |=> (m_stb_o && $stable(m_adr_o) && $stable(m_we_o)));

endmodule

// File: verilog/sdmac_top.sv
// SCSI DMA controller top with register block, word FIFO, port sequencer and bus master
module sdmac_top (
    input  logic        sclk_i,
    input  logic        arst_n_i,
    // CPU slave port
    input  logic        s_cyc_i,
    input  logic        s_stb_i,
    input  logic        s_we_i,
    input  logic [6:2]  s_adr_i,
    input  logic [31:0] s_dat_i,
    output logic [31:0] s_dat_o,
    output logic        s_ack_o,
    // Memory master port
    output logic        m_cyc_o,
    output logic        m_stb_o,
    output logic        m_we_o,
    output logic [31:0] m_adr_o,
    output logic [31:0] m_dat_o,
    input  logic [31:0] m_dat_i,
    input  logic        m_ack_i,
    // WD33C93 port
    input  logic        dreq_n_i,
    input  logic        intr_i,
    input  logic [15:0] pd_i,
    output logic [15:0] pd_o,
    output logic        pd_oe_o,
    output logic        dack_n_o,
    output logic        css_n_o,
    output logic        ior_n_o,
    output logic        iow_n_o,
    output logic        int_o
);

    logic        scsi_req;
    logic        scsi_we;
    logic [15:0] scsi_wdata;
    logic        scsi_done;
    logic [15:0] scsi_rdata;
    logic        word_done;
    logic        port_idle;
    logic        dma_run;
    logic        dma_dir;
    logic        dma_start;
    logic        preset;
    logic [31:0] acr;
    logic        fifo_empty;
    logic        fifo_full;
    logic [31:0] fifo_data;
    logic        fifo_push;
    logic [31:0] fifo_push_data;
    logic        fifo_pop;
    logic        port_push;
    logic [31:0] port_push_data;
    logic        port_pop;
    logic        mst_push;
    logic [31:0] mst_push_data;
    logic        mst_pop;

    // Port fills the FIFO for SCSI to memory, the master fills it otherwise
    assign fifo_push      = dma_dir ? mst_push : port_push;
    assign fifo_push_data = dma_dir ? mst_push_data : port_push_data;
    assign fifo_pop       = dma_dir ? port_pop : mst_pop;

    sdmac_regs u_regs (
        .sclk_i       (sclk_i),
        .arst_n_i     (arst_n_i),
        .s_cyc_i      (s_cyc_i),
        .s_stb_i      (s_stb_i),
        .s_we_i       (s_we_i),
        .s_adr_i      (s_adr_i),
        .s_dat_i      (s_dat_i),
        .scsi_done_i  (scsi_done),
        .scsi_rdata_i (scsi_rdata),
        .word_done_i  (word_done),
        .port_idle_i  (port_idle),
        .fifo_empty_i (fifo_empty),
        .fifo_full_i  (fifo_full),
        .intr_i       (intr_i),
        .s_dat_o      (s_dat_o),
        .s_ack_o      (s_ack_o),
        .scsi_req_o   (scsi_req),
        .scsi_we_o    (scsi_we),
        .scsi_wdata_o (scsi_wdata),
        .dma_run_o    (dma_run),
        .dma_dir_o    (dma_dir),
        .dma_start_o  (dma_start),
        .preset_o     (preset),
        .acr_o        (acr),
        .int_o        (int_o)
    );

    sdmac_fifo u_fifo (
        .sclk_i      (sclk_i),
        .arst_n_i    (arst_n_i),
        .clear_i     (dma_start),
        .push_i      (fifo_push),
        .push_data_i (fifo_push_data),
        .pop_i       (fifo_pop),
        .pop_data_o  (fifo_data),
        .full_o      (fifo_full),
        .empty_o     (fifo_empty)
    );

    scsi_port_sm u_port (
        .sclk_i           (sclk_i),
        .arst_n_i         (arst_n_i),
        .cpu_req_i        (scsi_req),
        .cpu_we_i         (scsi_we),
        .cpu_wdata_i      (scsi_wdata),
        .dma_run_i        (dma_run),
        .dma_dir_i        (dma_dir),
        .preset_i         (preset),
        .dreq_n_i         (dreq_n_i),
        .pd_i             (pd_i),
        .fifo_data_i      (fifo_data),
        .fifo_full_i      (fifo_full),
        .fifo_empty_i     (fifo_empty),
        .cpu_done_o       (scsi_done),
        .cpu_rdata_o      (scsi_rdata),
        .fifo_push_o      (port_push),
        .fifo_push_data_o (port_push_data),
        .fifo_pop_o       (port_pop),
        .port_idle_o      (port_idle),
        .pd_o             (pd_o),
        .pd_oe_o          (pd_oe_o),
        .dack_n_o         (dack_n_o),
        .css_n_o          (css_n_o),
        .ior_n_o          (ior_n_o),
        .iow_n_o          (iow_n_o)
    );

    dma_master_sm u_master (
        .sclk_i           (sclk_i),
        .arst_n_i         (arst_n_i),
        .dma_run_i        (dma_run),
        .dma_dir_i        (dma_dir),
        .acr_i            (acr),
        .fifo_data_i      (fifo_data),
        .fifo_empty_i     (fifo_empty),
        .fifo_full_i      (fifo_full),
        .m_dat_i          (m_dat_i),
        .m_ack_i          (m_ack_i),
        .m_cyc_o          (m_cyc_o),
        .m_stb_o          (m_stb_o),
        .m_we_o           (m_we_o),
        .m_adr_o          (m_adr_o),
        .m_dat_o          (m_dat_o),
        .fifo_push_o      (mst_push),
        .fifo_push_data_o (mst_push_data),
        .fifo_pop_o       (mst_pop),
        .word_done_o      (word_done)
    );

endmodule

// File: sim/tb_sdmac.sv
// Testbench for sdmac_top with trace reader, Wishbone memory model, SCSI chip model and watchdog
module tb_sdmac;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int          CLK_PERIOD      = 4;
    localparam logic [31:0] SEED            = 32'd6;
    localparam              TRACE_PATH      = "sim/sdmac_trace.txt";
    localparam int          CYCLES_PER_LINE = 200;
    localparam int          ACK_LIMIT       = 100;
    localparam int          DONE_LIMIT      = 4000;
    localparam int          SETTLE_CYCLES   = 50;
    localparam int          MEM_AW          = 12;           // 4096 words, 16 KiB
    localparam int          MEM_WORDS       = 1 << MEM_AW;
    localparam logic [31:0] FILL_KEY        = 32'h5a5a_5a5a;

    logic        sclk_i   = 1'b0;
    logic        arst_n_i = 1'b0;
    logic        s_cyc_i  = 1'b0;
    logic        s_stb_i  = 1'b0;
    logic        s_we_i   = 1'b0;
    logic [6:2]  s_adr_i  = '0;
    logic [31:0] s_dat_i  = '0;
    logic [31:0] s_dat_o;
    logic        s_ack_o;
    logic        m_cyc_o;
    logic        m_stb_o;
    logic        m_we_o;
    logic [31:0] m_adr_o;
    logic [31:0] m_dat_o;
    logic [31:0] m_dat_i  = '0;
    logic        m_ack_i  = 1'b0;
    logic        dreq_n_i = 1'b1;
    logic        intr_i   = 1'b0;
    logic [15:0] pd_i     = '0;
    logic [15:0] pd_o;
    logic        pd_oe_o;
    logic        dack_n_o;
    logic        css_n_o;
    logic        ior_n_o;
    logic        iow_n_o;
    logic        int_o;

    logic [31:0] mem_model [MEM_WORDS];
    logic [31:0] mem_rng         = SEED;
    logic [31:0] dreq_rng        = SEED;
    int          ack_wait        = -1;
    int unsigned words_acked     = 0;
    int unsigned css_cycles      = 0;
    int          watchdog_cycles = 0;
    logic [31:0] wtc_set         = '0;    // Last count written to WTC
    logic        dir_mem_to_scsi = 1'b0;
    logic [15:0] src_q [$];               // Halves the chip hands out
    logic [15:0] rx_q [$];                // Halves the chip has taken
    logic [15:0] chip_reg        = '0;
    logic [15:0] wr_half         = '0;
    logic        rd_strobe       = 1'b0;
    logic        wr_strobe       = 1'b0;

    sdmac_top u_dut (.*);

    always #(CLK_PERIOD / 2) sclk_i = ~sclk_i;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic mismatch_stop(input string what, input logic [31:0] exp,
                                 input logic [31:0] got);
        $display("** Error at %0t ns: %s expected %h, got %h", $time, what, exp, got);
        $display("Errors found");
        $fatal(1);
    endtask

    task automatic abort_run(input string msg);
        $display("%s (at %0t ns)", msg, $time);
        $display("Errors found");
        $fatal(1);
    endtask

    // One Wishbone classic cycle on the slave port
    task automatic slave_access(input logic we, input logic [6:0] off, input logic [31:0] data,
                                output logic [31:0] rdata);
        int n;
        s_cyc_i <= 1'b1;
        s_stb_i <= 1'b1;
        s_we_i  <= we;
        s_adr_i <= off[6:2];
        s_dat_i <= data;
        n = 0;
        do begin
            @(posedge sclk_i);
            n++;
        end while (!s_ack_o && n < ACK_LIMIT);
        assert (s_ack_o) else abort_run("Register access got no acknowledge");
        rdata   = s_dat_o;
        s_cyc_i <= 1'b0;
        s_stb_i <= 1'b0;
        s_we_i  <= 1'b0;
        @(posedge sclk_i);
    endtask

    task automatic run_to_done();
        logic [31:0] unused;
        int          n;
        slave_access(1'b1, 7'h10, '0, unused);       // ST_DMA
        n = 0;
        while (!int_o && n < DONE_LIMIT) begin
            @(posedge sclk_i);
            n++;
        end
        assert (int_o) else abort_run("Interrupt did not rise at the end of the DMA run");
    endtask

    task automatic wait_int_level(input logic level);
        int n;
        n = 0;
        while (int_o != level && n < 20) begin
            @(posedge sclk_i);
            n++;
        end
        assert (int_o == level) else mismatch_stop("int_o level", 32'(level), 32'(int_o));
    endtask

    // Start, stop after some words, then check the count left in WTC
    task automatic stop_after_words(input int unsigned k);
        logic [31:0] unused;
        int unsigned base;
        int unsigned moved;
        int          n;
        base = words_acked;
        slave_access(1'b1, 7'h10, '0, unused);
        n = 0;
        while (words_acked - base < k && n < DONE_LIMIT) begin
            @(posedge sclk_i);
            n++;
        end
        assert (words_acked - base >= k) else abort_run("DMA run moved too few words");
        slave_access(1'b1, 7'h14, '0, unused);       // SP_DMA
        repeat (SETTLE_CYCLES) @(posedge sclk_i);
        moved = words_acked - base;
        slave_access(1'b0, 7'h04, '0, unused);
        assert (unused == wtc_set - moved) else mismatch_stop("WTC after stop", wtc_set - moved,
                                                             unused);
        repeat (SETTLE_CYCLES) @(posedge sclk_i);
        assert (words_acked - base == moved)
            else mismatch_stop("Words after stop", moved, words_acked - base);
    endtask

    // Memory model, Wishbone classic slave with 0 to 3 wait cycles
    always @(posedge sclk_i) begin
        if (m_ack_i) begin
            m_ack_i <= 1'b0;
        end else if (m_cyc_o && m_stb_o) begin
            if (ack_wait < 0) begin
                mem_rng  = xorshift32(mem_rng);
                ack_wait = int'(mem_rng[1:0]);
            end
            if (ack_wait == 0) begin
                assert (m_adr_o < MEM_WORDS * 4) else abort_run("Memory access outside the model");
                if (m_we_o)
                    mem_model[m_adr_o[MEM_AW+1:2]] = m_dat_o;
                m_dat_i  <= mem_model[m_adr_o[MEM_AW+1:2]];
                m_ack_i  <= 1'b1;
                ack_wait = -1;
                words_acked++;
            end else begin
                ack_wait--;
            end
        end
    end

    // SCSI chip model with one window register and half-word queues
    always @(posedge sclk_i) begin
        if (!css_n_o) begin
            assert (dack_n_o) else abort_run("DACK active during a register window access");
            css_cycles++;
            if (!iow_n_o)
                chip_reg <= pd_o;
        end
        if (rd_strobe && dack_n_o)
            void'(src_q.pop_front());                // Half taken by the DUT
        if (wr_strobe && dack_n_o)
            rx_q.push_back(wr_half);
        rd_strobe = !dack_n_o && !ior_n_o;
        wr_strobe = !dack_n_o && !iow_n_o;
        if (wr_strobe) begin
            assert (pd_oe_o) else abort_run("Data bus not driven during a DMA write strobe");
            wr_half = pd_o;
        end
        pd_i     <= !css_n_o ? chip_reg : (src_q.size() != 0 ? src_q[0] : 16'h0000);
        dreq_rng = xorshift32(dreq_rng);
        dreq_n_i <= !((src_q.size() != 0 || dir_mem_to_scsi) && dreq_rng[1:0] != 2'b00);
    end

    initial begin
        int               watchdog_left;
        watchdog_left = 0;
        wait (watchdog_cycles != 0);
        watchdog_left = watchdog_cycles;
        repeat (watchdog_left) @(posedge sclk_i);
        $display("Watchdog expired after %0d cycles, the run did not finish", watchdog_left);
        $display("Errors found");
        $fatal(1);
    end

    initial begin
        int               fd;
        int               code;
        int               lines;
        int               i;
        int unsigned      css_before;
        logic [63:0]      cmd;
        logic [31:0]      a;
        logic [31:0]      d;
        logic [31:0]      got;
        logic [15:0]      hi;
        logic [15:0]      lo;
        logic [8*128-1:0] rest;

        for (i = 0; i < MEM_WORDS; i++)
            mem_model[i] = (32'(i) << 2) ^ FILL_KEY;   // Fill keyed on the byte address
        fd = $fopen(TRACE_PATH, "r");
        if (fd == 0)
            abort_run("Cannot open the trace file");
        lines = 0;
        while ($fgets(rest, fd) != 0)
            lines++;
        $fclose(fd);
        watchdog_cycles = (lines + 1) * CYCLES_PER_LINE;

        repeat (2) @(posedge sclk_i);
        arst_n_i <= 1'b1;
        @(posedge sclk_i);

        fd = $fopen(TRACE_PATH, "r");
        while ($fscanf(fd, "%s", cmd) == 1) begin
            if (cmd == "#") begin
                code = $fgets(rest, fd);
            end else begin
                code = $fscanf(fd, "%h %h", a, d);
                assert (code == 2) else abort_run("Malformed trace line");
                css_before = css_cycles;
                case (cmd)
                    "W": begin
                        slave_access(1'b1, a[6:0], d, got);
                        if (a[6:0] == 7'h04)
                            wtc_set = d;
                        if (a[6:0] == 7'h08)
                            dir_mem_to_scsi = d[1];
                    end
                    "R": begin
                        slave_access(1'b0, a[6:0], '0, got);
                        assert (got == d)
                            else mismatch_stop($sformatf("Register %02h", a[6:0]), d, got);
                    end
                    "M": mem_model[a[MEM_AW+1:2]] = d;
                    "S": begin
                        src_q.push_back(d[31:16]);
                        src_q.push_back(d[15:0]);
                    end
                    "D": run_to_done();
                    "E": begin
                        got = mem_model[a[MEM_AW+1:2]];
                        assert (got == d)
                            else mismatch_stop($sformatf("Memory word %08h", a), d, got);
                    end
                    "H": begin
                        assert (rx_q.size() >= 2) else abort_run("SCSI chip got too few halves");
                        hi = rx_q.pop_front();
                        lo = rx_q.pop_front();
                        assert ({hi, lo} == d) else mismatch_stop("SCSI half pair", d, {hi, lo});
                    end
                    "I": intr_i <= a[0];
                    "N": wait_int_level(a[0]);
                    "X": stop_after_words(a);
                    default: abort_run("Unknown trace command");
                endcase
                if ((cmd == "W" || cmd == "R") && a[6:0] == 7'h40)
                    assert (css_cycles != css_before)
                        else abort_run("No chip select during a window access");
            end
        end
        $fclose(fd);
        $display("No errors");
        $finish;
    end

endmodule

// File: sim/sdmac_trace.txt
# cmd arg data (hex): W write reg, R read reg and expect, M preload memory, E expect memory
# S chip source word, H expect chip word, D run DMA, I intr level, N expect int_o, X stop
R 1c 00000004
W 04 00000003
R 04 00000003
W 0c 00001000
R 0c 00001000
W 08 00000004
R 08 00000004
W 40 0000c3a5
R 40 0000c3a5
S 0 11112222
S 0 33334444
S 0 5555aaaa
D 0 0
E 1000 11112222
E 1004 33334444
E 1008 5555aaaa
R 0c 0000100c
R 04 00000000
R 1c 00000005
N 1 0
W 18 00000000
N 0 0
R 1c 00000004
I 1 0
R 1c 00000006
N 1 0
I 0 0
N 0 0
M 2000 cafef00d
M 2004 01234567
M 2008 89abcdef
W 04 00000003
W 0c 00002000
W 08 00000006
D 0 0
H 0 cafef00d
H 0 01234567
H 0 89abcdef
R 0c 0000200c
W 18 00000000
N 0 0
W 04 00000020
W 0c 00003000
X 4 0

// File: all.f
verilog/sdmac_pkg.sv
verilog/sdmac_fifo.sv
verilog/sdmac_regs.sv
verilog/scsi_port_sm.sv
verilog/dma_master_sm.sv
verilog/sdmac_top.sv
sim/tb_sdmac.sv
